// File: rtl/l2c_pkg.sv
/*
 * layer-2 normal-loop shared definitions
 * lane geometry, count width, lane masks and the controller enums
 */
package l2c_pkg;

    // ======================================================================
    // array geometry
    // ======================================================================
    localparam int LANES           = 32;  // fifo lanes per stream
    localparam int CNT_W           = 32;  // event counts and tile fields
    localparam int KERNEL_W        = 3;   // conv kernel width, ifmap stagger step

    localparam int DW_IFMAP_LANES  = 30;  // ifmap lanes for depthwise/standard
    localparam int CONV_PSUM_LANES = 10;  // ipsum/opsum lanes for depthwise/standard

    // ======================================================================
    // lane masks
    // ======================================================================
    localparam logic [LANES-1:0] ALL_LANES_MASK = '1;

    localparam logic [LANES-1:0] DW_IFMAP_MASK = {
        {(LANES - DW_IFMAP_LANES){1'b0}},
        {DW_IFMAP_LANES{1'b1}}
    };  // lanes 0..29

    localparam logic [LANES-1:0] CONV_PSUM_MASK = {
        {(LANES - CONV_PSUM_LANES){1'b0}},
        {CONV_PSUM_LANES{1'b1}}
    };  // lanes 0..9

    // ======================================================================
    // layer type, as sent by the layer-3 controller
    // ======================================================================
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_e;

    // ======================================================================
    // normal-loop FSM states
    // ======================================================================
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // wait for start
        SET_NUM   = 2'd1,  // one cycle, load all banks
        WAIT_DONE = 2'd2,  // lanes still draining
        DONE      = 2'd3   // one-cycle done pulse
    } nl_state_e;

endpackage

// File: rtl/l2c_lane_counter_bank.sv
/*
 * lane counter bank
 * one loadable down-counter per lane, tracks remaining pop/push events
 */
`timescale 1ns/1ns

module l2c_lane_counter_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_i,
    input  logic [l2c_pkg::LANES-1:0] need_i,
    input  logic [l2c_pkg::CNT_W-1:0] num_i [l2c_pkg::LANES],
    input  logic [l2c_pkg::LANES-1:0] event_i,
    output logic [l2c_pkg::LANES-1:0] done_o,
    output logic [l2c_pkg::LANES-1:0] pending_o
);
    import l2c_pkg::*;

    logic [CNT_W-1:0] cnt_q [LANES];  // remaining events per lane
    logic [LANES-1:0] lane_zero;

    // ======================================================================
    // per-lane counters
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < LANES; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (load_i) begin
                    cnt_q[k] <= need_i[k] ? num_i[k] : '0;  // unused lane parks at zero
                end else if (event_i[k] && !lane_zero[k]) begin
                    cnt_q[k] <= cnt_q[k] - CNT_W'(1);      // stops at zero
                end
            end
        end
    end

    // ======================================================================
    // lane status
    // ======================================================================
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_zero[k] = (cnt_q[k] == '0);
        end
    end

    assign done_o    = lane_zero;
    assign pending_o = ~lane_zero;

endmodule

// File: rtl/l2c_normal_loop.sv
/*
 * layer-2 normal-loop controller
 * works out per-lane need masks and event counts from the layer type and
 * tile geometry, loads them into the lane banks and waits for completion
 */
`timescale 1ns/1ns

module l2c_normal_loop (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  l2c_pkg::layer_e           layer_type_i,
    input  logic [l2c_pkg::CNT_W-1:0] tile_n_i,
    input  logic [l2c_pkg::CNT_W-1:0] on_real_i,
    input  logic [l2c_pkg::CNT_W-1:0] in_c_i,
    input  logic [l2c_pkg::CNT_W-1:0] pad_r_i,
    input  logic [l2c_pkg::CNT_W-1:0] pad_l_i,
    input  logic [l2c_pkg::CNT_W-1:0] out_c_i,
    input  logic [l2c_pkg::LANES-1:0] ifmap_done_i,
    input  logic [l2c_pkg::LANES-1:0] ipsum_done_i,
    input  logic [l2c_pkg::LANES-1:0] opsum_done_i,
    output logic                      load_o,
    output logic [l2c_pkg::LANES-1:0] ifmap_need_o,
    output logic [l2c_pkg::LANES-1:0] ipsum_need_o,
    output logic [l2c_pkg::LANES-1:0] opsum_need_o,
    output logic [l2c_pkg::CNT_W-1:0] ifmap_num_o [l2c_pkg::LANES],
    output logic [l2c_pkg::CNT_W-1:0] ipsum_num_o [l2c_pkg::LANES],
    output logic [l2c_pkg::CNT_W-1:0] opsum_num_o [l2c_pkg::LANES],
    output logic                      done_o
);
    import l2c_pkg::*;

    nl_state_e        state_q, state_d;
    logic             all_done;
    logic [CNT_W-1:0] pad_width;

    logic [LANES-1:0] ifmap_need, ipsum_need, opsum_need;
    logic [CNT_W-1:0] ifmap_cnt [LANES];
    logic [CNT_W-1:0] ipsum_cnt [LANES];
    logic [CNT_W-1:0] opsum_cnt [LANES];

    // a minus b, clamped at zero
    function automatic logic [CNT_W-1:0] sat_sub(input logic [CNT_W-1:0] a,
                                                 input logic [CNT_W-1:0] b);
        return (a > b) ? (a - b) : '0;
    endfunction

    // ======================================================================
    // loop FSM
    // ======================================================================
    assign all_done = (&ifmap_done_i) && (&ipsum_done_i) && (&opsum_done_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = SET_NUM;
                end
            end
            SET_NUM:   state_d = WAIT_DONE;
            WAIT_DONE: begin
                if (all_done) begin   // banks hold the new plan here
                    state_d = DONE;
                end
            end
            DONE:      state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    assign load_o = (state_q == SET_NUM);
    assign done_o = (state_q == DONE);

    // ======================================================================
    // per-lane planning
    // ======================================================================
    assign pad_width = in_c_i + pad_r_i + pad_l_i;  // padded row width

    always_comb begin
        ifmap_need = '0;
        for (int k = 0; k < LANES; k++) begin
            ifmap_cnt[k] = '0;
        end
        case (layer_type_i)
            POINTWISE: begin
                ifmap_need = ALL_LANES_MASK;
                for (int k = 0; k < LANES; k++) begin
                    ifmap_cnt[k] = tile_n_i;
                end
            end
            DEPTHWISE: begin
                ifmap_need = DW_IFMAP_MASK;
                // each group of three lanes starts one kernel step later
                for (int k = 0; k < DW_IFMAP_LANES; k++) begin
                    ifmap_cnt[k] = sat_sub(pad_width, CNT_W'(KERNEL_W * (k / KERNEL_W + 1)));
                end
            end
            STANDARD: begin
                ifmap_need = DW_IFMAP_MASK;
                for (int k = 0; k < DW_IFMAP_LANES; k++) begin
                    ifmap_cnt[k] = sat_sub(pad_width, CNT_W'(KERNEL_W));
                end
            end
            LINEAR: begin
                ifmap_need = ALL_LANES_MASK;
                for (int k = 0; k < LANES; k++) begin
                    ifmap_cnt[k] = sat_sub(tile_n_i, CNT_W'(1));
                end
            end
            default: ifmap_need = '0;
        endcase
    end

    always_comb begin
        ipsum_need = '0;
        for (int k = 0; k < LANES; k++) begin
            ipsum_cnt[k] = '0;
        end
        case (layer_type_i)
            POINTWISE: begin
                ipsum_need   = ALL_LANES_MASK;
                ipsum_cnt[0] = on_real_i;                 // lane 0 primed in preheat
                for (int k = 1; k < LANES; k++) begin
                    ipsum_cnt[k] = on_real_i + CNT_W'(1);
                end
            end
            LINEAR: begin
                ipsum_need   = ALL_LANES_MASK;
                ipsum_cnt[0] = sat_sub(on_real_i, CNT_W'(1));
                for (int k = 1; k < LANES; k++) begin
                    ipsum_cnt[k] = on_real_i;
                end
            end
            DEPTHWISE, STANDARD: begin
                ipsum_need   = CONV_PSUM_MASK;
                ipsum_cnt[0] = sat_sub(out_c_i, CNT_W'(1));
                for (int k = 1; k < CONV_PSUM_LANES; k++) begin
                    ipsum_cnt[k] = out_c_i;
                end
            end
            default: ipsum_need = '0;
        endcase
    end

    always_comb begin
        opsum_need = '0;
        for (int k = 0; k < LANES; k++) begin
            opsum_cnt[k] = '0;
        end
        case (layer_type_i)
            POINTWISE, LINEAR: begin
                opsum_need = ALL_LANES_MASK;
                for (int k = 0; k < LANES; k++) begin
                    opsum_cnt[k] = on_real_i;
                end
            end
            DEPTHWISE, STANDARD: begin
                opsum_need = CONV_PSUM_MASK;
                for (int k = 0; k < CONV_PSUM_LANES; k++) begin
                    opsum_cnt[k] = out_c_i;
                end
            end
            default: opsum_need = '0;
        endcase
    end

    // ======================================================================
    // plan outputs, valid only while loading
    // ======================================================================
    always_comb begin
        ifmap_need_o = load_o ? ifmap_need : '0;
        ipsum_need_o = load_o ? ipsum_need : '0;
        opsum_need_o = load_o ? opsum_need : '0;
        for (int k = 0; k < LANES; k++) begin
            ifmap_num_o[k] = (load_o && ifmap_need[k]) ? ifmap_cnt[k] : '0;
            ipsum_num_o[k] = (load_o && ipsum_need[k]) ? ipsum_cnt[k] : '0;
            opsum_num_o[k] = (load_o && opsum_need[k]) ? opsum_cnt[k] : '0;
        end
    end

endmodule

// File: rtl/l2c_normal_loop_top.sv
/*
 * layer-2 normal-loop stage
 * controller plus ifmap, ipsum and opsum lane counter banks
 */
`timescale 1ns/1ns

module l2c_normal_loop_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  l2c_pkg::layer_e           layer_type_i,
    input  logic [l2c_pkg::CNT_W-1:0] tile_n_i,
    input  logic [l2c_pkg::CNT_W-1:0] on_real_i,
    input  logic [l2c_pkg::CNT_W-1:0] in_c_i,
    input  logic [l2c_pkg::CNT_W-1:0] pad_r_i,
    input  logic [l2c_pkg::CNT_W-1:0] pad_l_i,
    input  logic [l2c_pkg::CNT_W-1:0] out_c_i,
    input  logic [l2c_pkg::LANES-1:0] ifmap_pop_i,
    input  logic [l2c_pkg::LANES-1:0] ipsum_pop_i,
    input  logic [l2c_pkg::LANES-1:0] opsum_push_i,
    output logic [l2c_pkg::LANES-1:0] ifmap_pending_o,
    output logic [l2c_pkg::LANES-1:0] ipsum_pending_o,
    output logic [l2c_pkg::LANES-1:0] opsum_pending_o,
    output logic                      done_o
);
    import l2c_pkg::*;

    logic             load;                // shared load pulse
    logic [LANES-1:0] ifmap_need, ipsum_need, opsum_need;
    logic [CNT_W-1:0] ifmap_num [LANES];
    logic [CNT_W-1:0] ipsum_num [LANES];
    logic [CNT_W-1:0] opsum_num [LANES];
    logic [LANES-1:0] ifmap_done, ipsum_done, opsum_done;

    // ======================================================================
    // controller
    // ======================================================================
    l2c_normal_loop u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .layer_type_i (layer_type_i),
        .tile_n_i     (tile_n_i),
        .on_real_i    (on_real_i),
        .in_c_i       (in_c_i),
        .pad_r_i      (pad_r_i),
        .pad_l_i      (pad_l_i),
        .out_c_i      (out_c_i),
        .ifmap_done_i (ifmap_done),
        .ipsum_done_i (ipsum_done),
        .opsum_done_i (opsum_done),
        .load_o       (load),
        .ifmap_need_o (ifmap_need),
        .ipsum_need_o (ipsum_need),
        .opsum_need_o (opsum_need),
        .ifmap_num_o  (ifmap_num),
        .ipsum_num_o  (ipsum_num),
        .opsum_num_o  (opsum_num),
        .done_o       (done_o)
    );

    // ======================================================================
    // counter banks
    // ======================================================================
    l2c_lane_counter_bank u_ifmap_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .need_i    (ifmap_need),
        .num_i     (ifmap_num),
        .event_i   (ifmap_pop_i),      // ifmap fifo pops
        .done_o    (ifmap_done),
        .pending_o (ifmap_pending_o)
    );

    l2c_lane_counter_bank u_ipsum_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .need_i    (ipsum_need),
        .num_i     (ipsum_num),
        .event_i   (ipsum_pop_i),      // ipsum fifo pops
        .done_o    (ipsum_done),
        .pending_o (ipsum_pending_o)
    );

    l2c_lane_counter_bank u_opsum_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .need_i    (opsum_need),
        .num_i     (opsum_num),
        .event_i   (opsum_push_i),     // opsum fifo pushes
        .done_o    (opsum_done),
        .pending_o (opsum_pending_o)
    );

endmodule

// File: dv/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 4 ns clock, active-low reset held for 5 cycles
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;          // half of the 4 ns period
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                 // release away from the rising edge
    end

endmodule

// File: dv/tb_l2c_normal_loop.sv
/*
 * testbench for the layer-2 normal-loop stage
 * random geometry and lane strobes, checked against a lane counting model
 */
`timescale 1ns/1ns

module tb_l2c_normal_loop;
    import l2c_pkg::*;

    localparam int DRAIN_LIMIT = 400;   // cycles to drain one plan
    localparam int DONE_LIMIT  = 16;
    localparam int RESET_LIMIT = 20;

    logic             clk, rst_n;
    logic             start;
    layer_e           layer;
    logic [CNT_W-1:0] tile_n, on_real, in_c, pad_r, pad_l, out_c;
    logic [LANES-1:0] strobe [3];       // ifmap pop, ipsum pop, opsum push
    logic [LANES-1:0] ifmap_pending, ipsum_pending, opsum_pending;
    logic             done;

    logic [CNT_W-1:0] model_cnt [3][LANES];  // events still expected per lane
    logic [31:0]      lfsr_state;
    logic             done_last = 1'b0;
    int               errors;
    int               monitor_errors = 0;
    int               timeouts;

    tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    l2c_normal_loop_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start),
        .layer_type_i    (layer),
        .tile_n_i        (tile_n),
        .on_real_i       (on_real),
        .in_c_i          (in_c),
        .pad_r_i         (pad_r),
        .pad_l_i         (pad_l),
        .out_c_i         (out_c),
        .ifmap_pop_i     (strobe[0]),
        .ipsum_pop_i     (strobe[1]),
        .opsum_push_i    (strobe[2]),
        .ifmap_pending_o (ifmap_pending),
        .ipsum_pending_o (ipsum_pending),
        .opsum_pending_o (opsum_pending),
        .done_o          (done)
    );

    // ======================================================================
    // random source and counting model
    // ======================================================================
    function automatic logic random_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;  // galois taps
        end
        return lsb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], random_bit()};
        end
        return val;
    endfunction

    function automatic logic [CNT_W-1:0] clamp_sub(input logic [CNT_W-1:0] a, b);
        return (b >= a) ? '0 : a - b;
    endfunction

    // expected events for stream s, lane k; unused lanes give zero
    function automatic logic [CNT_W-1:0] plan_count(input int s, input int k);
        logic [CNT_W-1:0] width;
        logic             conv;
        logic [CNT_W-1:0] n;
        width = in_c + pad_r + pad_l;
        conv  = (layer == DEPTHWISE) || (layer == STANDARD);
        n     = '0;
        if (s == 0) begin
            if (layer == POINTWISE) n = tile_n;
            else if (layer == LINEAR) n = clamp_sub(tile_n, 1);
            else if (k < 30) n = clamp_sub(width, (layer == DEPTHWISE) ? 3 * (k / 3 + 1) : 3);
        end else if (conv) begin
            if (k < 10) n = (s == 1 && k == 0) ? clamp_sub(out_c, 1) : out_c;
        end else if (s == 2) begin
            n = on_real;
        end else if (layer == POINTWISE) begin
            n = (k == 0) ? on_real : on_real + 1;
        end else begin
            n = (k == 0) ? clamp_sub(on_real, 1) : on_real;
        end
        return n;
    endfunction

    task automatic load_model();
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < LANES; k++) begin
                model_cnt[s][k] = plan_count(s, k);
            end
        end
    endtask

    function automatic logic [LANES-1:0] model_pending(input int s);
        logic [LANES-1:0] m;
        for (int k = 0; k < LANES; k++) begin
            m[k] = (model_cnt[s][k] != 0);
        end
        return m;
    endfunction

    function automatic logic model_drained();
        return (model_pending(0) | model_pending(1) | model_pending(2)) == '0;
    endfunction

    // strobes sampled at the next rising edge, model counts them now
    task automatic drive_random_strobes();
        for (int s = 0; s < 3; s++) begin
            strobe[s] = random_bits(LANES);
            for (int k = 0; k < LANES; k++) begin
                if (strobe[s][k] && model_cnt[s][k] != 0) begin
                    model_cnt[s][k] = model_cnt[s][k] - 1;
                end
            end
        end
    endtask

    task automatic clear_strobes();
        for (int s = 0; s < 3; s++) begin
            strobe[s] = '0;
        end
    endtask

    // ======================================================================
    // checks
    // ======================================================================
    task automatic expect_value(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pending();
        expect_value("ifmap_pending_o", ifmap_pending, model_pending(0));
        expect_value("ipsum_pending_o", ipsum_pending, model_pending(1));
        expect_value("opsum_pending_o", opsum_pending, model_pending(2));
    endtask

    task automatic check_outputs(input logic exp_done);
        check_pending();
        expect_value("done_o", {31'b0, done}, {31'b0, exp_done});
    endtask

    // done is a single-cycle pulse and never rises over pending lanes
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(done && done_last)) else begin
                monitor_errors++;
                $display("done_o stayed high for more than one cycle");
            end
            assert (!(done && (|{ifmap_pending, ipsum_pending, opsum_pending}))) else begin
                monitor_errors++;
                $display("done_o rose while lanes were still pending");
            end
        end
        done_last <= done;
    end

    // ======================================================================
    // loop sequences
    // ======================================================================
    task automatic drain_lanes();
        int cycles;
        cycles = 0;
        while (!model_drained() && cycles < DRAIN_LIMIT) begin
            drive_random_strobes();
            @(negedge clk);
            cycles++;
            check_outputs(1'b0);
        end
        clear_strobes();
        if (!model_drained()) begin
            timeouts++;
            $display("lanes still pending after %0d cycles of strobes", cycles);
        end
    endtask

    // done_o expected at the edge right after the last counting edge
    task automatic wait_for_done();
        int edges;
        edges = 0;
        while (done !== 1'b1 && edges < DONE_LIMIT) begin
            drive_random_strobes();     // drained lanes ignore these
            @(negedge clk);
            edges++;
            check_pending();
        end
        clear_strobes();
        if (done !== 1'b1) begin
            timeouts++;
            $display("done_o never rose after all lanes drained");
        end else begin
            expect_value("done_o latency", edges, 1);
            @(negedge clk);
            check_outputs(1'b0);
        end
    endtask

    task automatic run_loop(input layer_e lt, input logic [CNT_W-1:0] tn, orl, ic, pr, pl, oc,
                            input logic hold_start);
        layer   = lt;
        tile_n  = tn;
        on_real = orl;
        in_c    = ic;
        pad_r   = pr;
        pad_l   = pl;
        out_c   = oc;
        start   = 1'b1;
        @(negedge clk);                 // start sampled, banks not loaded yet
        start = hold_start;
        check_outputs(1'b0);
        load_model();
        @(negedge clk);                 // load edge passed
        check_outputs(1'b0);
        drain_lanes();
        start = 1'b0;
        wait_for_done();
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int cycles;
        start      = 1'b0;
        layer      = POINTWISE;
        tile_n     = '0;
        on_real    = '0;
        in_c       = '0;
        pad_r      = '0;
        pad_l      = '0;
        out_c      = '0;
        lfsr_state = 32'hab0f88ea;
        errors     = 0;
        timeouts   = 0;
        clear_strobes();
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < LANES; k++) begin
                model_cnt[s][k] = '0;
            end
        end

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_LIMIT) begin
            @(negedge clk);
            cycles++;
            check_outputs(1'b0);
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end

        // strobes while idle must leave everything at zero
        for (int i = 0; i < 4; i++) begin
            drive_random_strobes();
            @(negedge clk);
            check_outputs(1'b0);
        end
        clear_strobes();

        for (int i = 0; i < 8; i++) begin
            run_loop(layer_e'(i % 4), random_bits(4), random_bits(4), random_bits(4),
                     random_bits(2), random_bits(2), random_bits(4), 1'b0);
        end

        run_loop(LINEAR, 0, 5, 4, 1, 1, 3, 1'b0);       // ifmap lanes load as zero
        run_loop(DEPTHWISE, 6, 2, 7, 0, 0, 4, 1'b0);    // stagger clamps from lane 6
        run_loop(STANDARD, 3, 2, 1, 1, 0, 1, 1'b0);     // pad width below kernel
        run_loop(LINEAR, 0, 0, 9, 2, 2, 7, 1'b0);       // nothing to count at all
        run_loop(POINTWISE, 5, 6, 2, 1, 1, 2, 1'b1);    // start held during the loop
        run_loop(DEPTHWISE, 3, 3, 12, 1, 2, 5, 1'b0);

        errors = errors + monitor_errors;
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/l2c_pkg.sv
rtl/l2c_lane_counter_bank.sv
rtl/l2c_normal_loop.sv
rtl/l2c_normal_loop_top.sv
dv/tb_clock_gen.sv
dv/tb_l2c_normal_loop.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the normal-loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns \
    --top-module tb_l2c_normal_loop -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_l2c_normal_loop)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if echo "${sim_out}" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
